// ==== Makefile ====
SIM := obj_dir/Vtb_core

.PHONY: all run clean

all: $(SIM)

# Rebuilt only when the file list or a listed source changes
$(SIM): compile.f $(shell cat compile.f)
	verilator --binary --timing --assert --top-module tb_core -f compile.f

# Pass only if the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'TEST OK'

clean:
	rm -rf obj_dir

// ==== compile.f ====
rtl/core_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/register_file.sv
rtl/execute_stage.sv
rtl/core_top.sv
tb/tb_core.sv

// ==== rtl/core_pkg.sv ====
`default_nettype none

package core_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  typedef logic [31:0] xlen_t;      // Data or address word
  typedef logic [31:0] instr_t;     // Raw instruction word
  typedef logic [4:0]  reg_addr_t;  // Register index

  // Major opcodes still decoded
  typedef enum logic [6:0] {
    OPCODE_OP_IMM = 7'h13,
    OPCODE_OP     = 7'h33,
    OPCODE_LUI    = 7'h37
  } opcode_e;

  // ALU operations, LUI runs as ADD with a zero operand a
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_e;

  ////////////////////////////////////////
  // Stage payloads
  ////////////////////////////////////////

  typedef struct packed {
    logic   valid;  // One-cycle strobe per fetched word
    instr_t instr;
    xlen_t  pc;
  } if_id_t;

  typedef struct packed {
    logic      valid;
    alu_op_e   alu_op;
    xlen_t     op_a;
    xlen_t     op_b;
    reg_addr_t rd;
    logic      we;     // Cleared for x0, illegal and RV32E misses
    xlen_t     pc;
  } id_ex_t;

  typedef struct packed {
    logic      valid;
    reg_addr_t rd;
    logic      we;
    xlen_t     result;
  } ex_wb_t;

  // EX result travelling back to ID in the same cycle
  typedef struct packed {
    logic      we;
    reg_addr_t rd;
    xlen_t     value;
  } fwd_t;

endpackage

`default_nettype wire

// ==== rtl/core_top.sv ====
`default_nettype none

module core_top #(
  parameter bit RV32E = 1'b0
) (
  input  wire logic                 clk_i,
  input  wire logic                 rst_i,
  input  wire core_pkg::xlen_t      boot_addr_i,
  input  wire logic                 fetch_enable_i,
  // Instruction bus
  output logic                      instr_req_o,
  output core_pkg::xlen_t           instr_addr_o,
  input  wire logic                 instr_gnt_i,
  input  wire logic                 instr_rvalid_i,
  input  wire core_pkg::instr_t     instr_rdata_i,
  // Write port, observed by the testbench
  output logic                      rf_we_wb_o,
  output core_pkg::reg_addr_t       rf_waddr_wb_o,
  output core_pkg::xlen_t           rf_wdata_wb_o,
  output logic                      core_busy_o
);

  core_pkg::if_id_t    if_id;
  core_pkg::id_ex_t    id_ex;
  core_pkg::ex_wb_t    ex_wb;
  core_pkg::fwd_t      fwd;
  core_pkg::reg_addr_t rf_raddr_a;
  core_pkg::reg_addr_t rf_raddr_b;
  core_pkg::xlen_t     rf_rdata_a;
  core_pkg::xlen_t     rf_rdata_b;
  logic                if_busy;

  ////////////////////////////////////////
  // Pipeline
  ////////////////////////////////////////

  fetch_stage i_fetch_stage (
    .clk_i          (clk_i),
    .rst_i          (rst_i),
    .boot_addr_i    (boot_addr_i),
    .fetch_enable_i (fetch_enable_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .if_id_o        (if_id),
    .if_busy_o      (if_busy)
  );

  decode_stage #(.RV32E(RV32E)) i_decode_stage (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .if_id_i      (if_id),
    .rf_raddr_a_o (rf_raddr_a),
    .rf_raddr_b_o (rf_raddr_b),
    .rf_rdata_a_i (rf_rdata_a),
    .rf_rdata_b_i (rf_rdata_b),
    .fwd_i        (fwd),       // EX bypass
    .id_ex_o      (id_ex)
  );

  register_file #(.RV32E(RV32E)) i_register_file (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .raddr_a_i (rf_raddr_a),
    .raddr_b_i (rf_raddr_b),
    .rdata_a_o (rf_rdata_a),
    .rdata_b_o (rf_rdata_b),
    .wb_i      (ex_wb)        // Write port, write-through on reads
  );

  execute_stage i_execute_stage (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .id_ex_i (id_ex),
    .fwd_o   (fwd),
    .ex_wb_o (ex_wb)
  );

  assign rf_we_wb_o    = ex_wb.valid && ex_wb.we;
  assign rf_waddr_wb_o = ex_wb.rd;
  assign rf_wdata_wb_o = ex_wb.result;

  // Busy while fetching or anything still in flight
  assign core_busy_o = if_busy || if_id.valid || id_ex.valid || ex_wb.valid;

endmodule

`default_nettype wire

// ==== rtl/decode_stage.sv ====
`default_nettype none

module decode_stage #(
  parameter bit RV32E = 1'b0
) (
  input  wire logic               clk_i,
  input  wire logic               rst_i,
  input  wire core_pkg::if_id_t   if_id_i,
  // Register file reads
  output core_pkg::reg_addr_t     rf_raddr_a_o,
  output core_pkg::reg_addr_t     rf_raddr_b_o,
  input  wire core_pkg::xlen_t    rf_rdata_a_i,
  input  wire core_pkg::xlen_t    rf_rdata_b_i,
  // Bypass from EX
  input  wire core_pkg::fwd_t     fwd_i,
  output core_pkg::id_ex_t        id_ex_o
);

  core_pkg::instr_t    instr;
  core_pkg::reg_addr_t rd;
  core_pkg::reg_addr_t rs1;
  core_pkg::reg_addr_t rs2;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  core_pkg::xlen_t     imm_i;
  core_pkg::xlen_t     imm_u;
  core_pkg::xlen_t     rs1_val;
  core_pkg::xlen_t     rs2_val;
  core_pkg::alu_op_e   base_op;
  core_pkg::alu_op_e   alu_op;
  core_pkg::xlen_t     op_a;
  core_pkg::xlen_t     op_b;
  logic                illegal;
  logic                uses_rs1;
  logic                uses_rs2;
  logic                rv32e_bad;
  core_pkg::id_ex_t    id_ex_q;

  // Field split
  assign instr  = if_id_i.instr;
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct7 = instr[31:25];
  assign imm_i  = {{20{instr[31]}}, instr[31:20]};  // Sign extended
  assign imm_u  = {instr[31:12], 12'b0};

  assign rf_raddr_a_o = rs1;
  assign rf_raddr_b_o = rs2;

  ////////////////////////////////////////
  // Operand bypass
  ////////////////////////////////////////

  // fwd_i.we never set for x0, so no zero check needed here
  assign rs1_val = (fwd_i.we && fwd_i.rd == rs1) ? fwd_i.value : rf_rdata_a_i;
  assign rs2_val = (fwd_i.we && fwd_i.rd == rs2) ? fwd_i.value : rf_rdata_b_i;

  // funct3 map shared by OP and OP-IMM
  always_comb begin
    case (funct3)
      3'b000:  base_op = core_pkg::ALU_ADD;
      3'b001:  base_op = core_pkg::ALU_SLL;
      3'b010:  base_op = core_pkg::ALU_SLT;
      3'b011:  base_op = core_pkg::ALU_SLTU;
      3'b100:  base_op = core_pkg::ALU_XOR;
      3'b101:  base_op = core_pkg::ALU_SRL;
      3'b110:  base_op = core_pkg::ALU_OR;
      default: base_op = core_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    alu_op   = base_op;
    illegal  = 1'b0;
    uses_rs1 = 1'b1;
    uses_rs2 = 1'b0;
    op_a     = rs1_val;
    op_b     = imm_i;
    case (core_pkg::opcode_e'(instr[6:0]))
      core_pkg::OPCODE_OP: begin
        uses_rs2 = 1'b1;
        op_b     = rs2_val;
        if (funct7 == 7'b0100000 && funct3 == 3'b000) alu_op = core_pkg::ALU_SUB;
        else if (funct7 == 7'b0100000 && funct3 == 3'b101) alu_op = core_pkg::ALU_SRA;
        else if (funct7 != 7'b0000000) illegal = 1'b1;
      end
      core_pkg::OPCODE_OP_IMM: begin
        if (funct3 == 3'b001 && funct7 != 7'b0000000) illegal = 1'b1;  // Bad SLLI
        if (funct3 == 3'b101) begin
          if (funct7 == 7'b0100000) alu_op = core_pkg::ALU_SRA;
          else if (funct7 != 7'b0000000) illegal = 1'b1;
        end
      end
      core_pkg::OPCODE_LUI: begin
        uses_rs1 = 1'b0;            // Bits 19:15 belong to the immediate
        alu_op   = core_pkg::ALU_ADD;
        op_a     = '0;
        op_b     = imm_u;
      end
      default: illegal = 1'b1;      // Retires as no-op
    endcase
  end

  // x16..x31 absent in RV32E
  assign rv32e_bad = RV32E && (rd[4] || (uses_rs1 && rs1[4]) || (uses_rs2 && rs2[4]));

  ////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      id_ex_q.valid <= 1'b0;
      id_ex_q.we    <= 1'b0;
    end else begin
      id_ex_q.valid  <= if_id_i.valid;
      id_ex_q.we     <= if_id_i.valid && !illegal && !rv32e_bad && (rd != '0);
      id_ex_q.alu_op <= alu_op;
      id_ex_q.op_a   <= op_a;
      id_ex_q.op_b   <= op_b;
      id_ex_q.rd     <= rd;
      id_ex_q.pc     <= if_id_i.pc;
    end
  end

  assign id_ex_o = id_ex_q;

  // Bypass match above skips the x0 compare
  a_we_rd_legal: assert property (@(posedge clk_i) disable iff (rst_i)
    fwd_i.we |-> (fwd_i.rd != '0 && !(RV32E && fwd_i.rd[4])))
    else $error("bypass write enable with rd %0h", fwd_i.rd);

endmodule

`default_nettype wire

// ==== rtl/execute_stage.sv ====
`default_nettype none

module execute_stage (
  input  wire logic             clk_i,
  input  wire logic             rst_i,
  input  wire core_pkg::id_ex_t id_ex_i,
  output core_pkg::fwd_t        fwd_o,    // Combinational bypass to ID
  output core_pkg::ex_wb_t      ex_wb_o
);

  core_pkg::xlen_t  op_a;
  core_pkg::xlen_t  op_b;
  logic [4:0]       shamt;
  core_pkg::xlen_t  alu_result;
  core_pkg::ex_wb_t ex_wb_q;

  ////////////////////////////////////////
  // ALU
  ////////////////////////////////////////

  assign op_a  = id_ex_i.op_a;
  assign op_b  = id_ex_i.op_b;
  assign shamt = op_b[4:0];  // Upper bits ignored

  always_comb begin
    case (id_ex_i.alu_op)
      core_pkg::ALU_ADD:  alu_result = op_a + op_b;
      core_pkg::ALU_SUB:  alu_result = op_a - op_b;
      core_pkg::ALU_SLL:  alu_result = op_a << shamt;
      core_pkg::ALU_SLT:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      core_pkg::ALU_SLTU: alu_result = {31'b0, op_a < op_b};
      core_pkg::ALU_XOR:  alu_result = op_a ^ op_b;
      core_pkg::ALU_SRL:  alu_result = op_a >> shamt;
      core_pkg::ALU_SRA:  alu_result = $unsigned($signed(op_a) >>> shamt);  // Sign fill
      core_pkg::ALU_OR:   alu_result = op_a | op_b;
      default:            alu_result = op_a & op_b;
    endcase
  end

  // Result of the instruction in EX right now
  assign fwd_o.we    = id_ex_i.valid && id_ex_i.we;
  assign fwd_o.rd    = id_ex_i.rd;
  assign fwd_o.value = alu_result;

  ////////////////////////////////////////
  // EX/WB register
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ex_wb_q.valid <= 1'b0;
      ex_wb_q.we    <= 1'b0;
    end else begin
      ex_wb_q.valid  <= id_ex_i.valid;
      ex_wb_q.we     <= id_ex_i.valid && id_ex_i.we;
      ex_wb_q.rd     <= id_ex_i.rd;
      ex_wb_q.result <= alu_result;
    end
  end

  assign ex_wb_o = ex_wb_q;

  // PC from fetch survives decode word aligned
  a_pc_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
    id_ex_i.valid |-> (id_ex_i.pc[1:0] == 2'b00))
    else $error("misaligned pc %08h in EX", id_ex_i.pc);

endmodule

`default_nettype wire

// ==== rtl/fetch_stage.sv ====
`default_nettype none

module fetch_stage (
  input  wire logic            clk_i,
  input  wire logic            rst_i,
  input  wire core_pkg::xlen_t boot_addr_i,
  input  wire logic            fetch_enable_i,
  // Instruction bus
  output logic                 instr_req_o,
  output core_pkg::xlen_t      instr_addr_o,
  input  wire logic            instr_gnt_i,
  input  wire logic            instr_rvalid_i,
  input  wire core_pkg::instr_t instr_rdata_i,
  // To decode
  output core_pkg::if_id_t     if_id_o,
  output logic                 if_busy_o
);

  typedef enum logic {
    IF_IDLE,       // No response outstanding
    IF_WAIT_RESP   // Address phase done, data pending
  } if_state_e;

  if_state_e        state_q;
  core_pkg::xlen_t  pc_q;       // Next fetch address
  core_pkg::xlen_t  resp_pc_q;  // Address of the outstanding word
  logic             req_hold_q; // Raised but not yet granted
  logic             can_req;
  core_pkg::if_id_t if_id_q;

  ////////////////////////////////////////
  // Request side
  ////////////////////////////////////////

  // Free slot, or the outstanding word returns this cycle
  assign can_req      = (state_q == IF_IDLE) || instr_rvalid_i;
  assign instr_req_o  = can_req && (fetch_enable_i || req_hold_q); // Held past enable drop
  assign instr_addr_o = pc_q;
  assign if_busy_o    = instr_req_o || (state_q == IF_WAIT_RESP);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q    <= IF_IDLE;
      pc_q       <= boot_addr_i;  // Boot address taken during reset
      req_hold_q <= 1'b0;
    end else begin
      req_hold_q <= instr_req_o && !instr_gnt_i;
      if (instr_req_o && instr_gnt_i) begin
        state_q <= IF_WAIT_RESP;  // Grant wins over a same-cycle rvalid
        pc_q    <= pc_q + 32'd4;
      end else if (instr_rvalid_i) begin
        state_q <= IF_IDLE;
      end
    end
  end

  ////////////////////////////////////////
  // Response side and IF/ID
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (instr_req_o && instr_gnt_i) begin
      resp_pc_q <= pc_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      if_id_q.valid <= 1'b0;
    end else begin
      if_id_q.valid <= instr_rvalid_i;  // Strobe, no stall behind it
      if_id_q.instr <= instr_rdata_i;
      if_id_q.pc    <= resp_pc_q;
    end
  end

  assign if_id_o = if_id_q;

  // Bus rule, nothing may change while waiting on grant
  a_req_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (instr_req_o && !instr_gnt_i) |=> (instr_req_o && $stable(instr_addr_o)))
    else $error("instr req or addr changed before grant");

  // Responder must only answer a granted request
  a_rvalid_outstanding: assert property (@(posedge clk_i) disable iff (rst_i)
    instr_rvalid_i |-> (state_q == IF_WAIT_RESP))
    else $error("instr rvalid with no response outstanding");

endmodule

`default_nettype wire

// ==== rtl/register_file.sv ====
`default_nettype none

module register_file #(
  parameter bit RV32E = 1'b0
) (
  input  wire logic                clk_i,
  input  wire logic                rst_i,
  input  wire core_pkg::reg_addr_t raddr_a_i,
  input  wire core_pkg::reg_addr_t raddr_b_i,
  output core_pkg::xlen_t          rdata_a_o,
  output core_pkg::xlen_t          rdata_b_o,
  input  wire core_pkg::ex_wb_t    wb_i
);

  localparam int NUM_REGS = RV32E ? 16 : 32;
  localparam int ADDR_W   = RV32E ? 4 : 5;

  core_pkg::xlen_t     regs_q [NUM_REGS];
  core_pkg::reg_addr_t raddr  [2];
  core_pkg::xlen_t     rdata  [2];
  logic                wr_en;

  // x0 and out-of-range writes dropped
  assign wr_en = wb_i.valid && wb_i.we && (wb_i.rd != '0) && !(RV32E && wb_i.rd[4]);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[wb_i.rd[ADDR_W-1:0]] <= wb_i.result;
    end
  end

  assign raddr[0] = raddr_a_i;
  assign raddr[1] = raddr_b_i;

  for (genvar p = 0; p < 2; p++) begin : g_read
    always_comb begin
      if (raddr[p] == '0) rdata[p] = '0;                                   // Hardwired zero
      else if (wr_en && wb_i.rd == raddr[p]) rdata[p] = wb_i.result;       // Write-through
      else if (RV32E && raddr[p][4]) rdata[p] = '0;
      else rdata[p] = regs_q[raddr[p][ADDR_W-1:0]];
    end
  end

  assign rdata_a_o = rdata[0];
  assign rdata_b_o = rdata[1];

endmodule

`default_nettype wire

// ==== tb/tb_core.sv ====
`default_nettype none

module tb_core;

  timeunit 1ns;
  timeprecision 1ps;

  localparam core_pkg::xlen_t BOOT_ADDR = 32'h0000_1000;
  localparam int NUM_INSTR = 28;
  localparam int PAUSE_AT  = 12;    // Grants before fetch is paused
  localparam int TIMEOUT   = 1000;  // Cycles per wait

  // Expected register write
  typedef struct packed {
    core_pkg::reg_addr_t rd;
    core_pkg::xlen_t     value;
  } wr_t;

  logic                clk          = 1'b0;
  logic                rst          = 1'b1;
  core_pkg::xlen_t     boot_addr    = BOOT_ADDR;
  logic                fetch_enable = 1'b0;
  logic                instr_gnt    = 1'b0;
  logic                instr_rvalid = 1'b0;
  core_pkg::instr_t    instr_rdata  = '0;
  logic                instr_req;
  core_pkg::xlen_t     instr_addr;
  logic                rf_we_wb;
  core_pkg::reg_addr_t rf_waddr_wb;
  core_pkg::xlen_t     rf_wdata_wb;
  logic                core_busy;

  core_pkg::instr_t prog [NUM_INSTR];
  core_pkg::xlen_t  ref_regs [32];   // Reference register state
  wr_t              exp_writes [$];  // Program order
  logic [2:0]       we_pipe;         // Write strobe delayed to WB
  core_pkg::xlen_t  next_addr;
  int               retired;
  int               predicted;
  int               observed;
  // Responder state
  logic             pending;
  int               resp_idx;
  int               resp_wait;
  int               gnt_wait;

  always #10 clk = ~clk;

  core_top i_core_top (
    .clk_i          (clk),
    .rst_i          (rst),
    .boot_addr_i    (boot_addr),
    .fetch_enable_i (fetch_enable),
    .instr_req_o    (instr_req),
    .instr_addr_o   (instr_addr),
    .instr_gnt_i    (instr_gnt),
    .instr_rvalid_i (instr_rvalid),
    .instr_rdata_i  (instr_rdata),
    .rf_we_wb_o     (rf_we_wb),
    .rf_waddr_wb_o  (rf_waddr_wb),
    .rf_wdata_wb_o  (rf_wdata_wb),
    .core_busy_o    (core_busy)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  ////////////////////////////////////////
  // Encoders and reference model
  ////////////////////////////////////////

  function automatic core_pkg::instr_t enc_r(input int f7, input int rs2, input int rs1,
                                             input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction

  function automatic core_pkg::instr_t enc_i(input int imm, input int rs1, input int f3,
                                             input int rd);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'h13};
  endfunction

  function automatic core_pkg::instr_t enc_u(input int imm20, input int rd);
    return {imm20[19:0], rd[4:0], 7'h37};
  endfunction

  // RV32I semantics for the kept subset
  function automatic void predict(input core_pkg::instr_t w, output logic we,
                                  output core_pkg::reg_addr_t rd, output core_pkg::xlen_t val);
    core_pkg::xlen_t a;
    core_pkg::xlen_t b;
    logic            reg_form;
    logic            alt;    // funct7 0100000
    logic            legal;
    a        = ref_regs[w[19:15]];
    reg_form = (w[6:0] == 7'h33);
    b        = reg_form ? ref_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
    alt      = (w[31:25] == 7'h20);
    rd       = w[11:7];
    val      = '0;
    legal    = 1'b0;
    if (w[6:0] == 7'h37) begin
      legal = 1'b1;
      val   = {w[31:12], 12'h000};
    end else if (reg_form || w[6:0] == 7'h13) begin
      // Immediate forms other than shifts own bits 31:25
      if (!reg_form && w[14:12] != 3'd1 && w[14:12] != 3'd5) legal = 1'b1;
      else legal = (w[31:25] == 7'h00) ||
                   (alt && (w[14:12] == 3'd5 || (reg_form && w[14:12] == 3'd0)));
      case (w[14:12])
        3'd0: val = (reg_form && alt) ? a - b : a + b;
        3'd1: val = a << b[4:0];
        3'd2: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3: val = (a < b) ? 32'd1 : 32'd0;
        3'd4: val = a ^ b;
        3'd5: begin
          if (alt) val = $signed(a) >>> b[4:0];  // Arithmetic
          else val = a >> b[4:0];
        end
        3'd6: val = a | b;
        default: val = a & b;
      endcase
    end
    we = legal && (rd != 5'd0);  // x0 never written
  endfunction

  ////////////////////////////////////////
  // Instruction memory responder
  ////////////////////////////////////////

  always @(posedge clk) begin
    if (rst) begin
      instr_gnt    <= 1'b0;
      instr_rvalid <= 1'b0;
      pending   = 1'b0;
      gnt_wait  = 1;
    end else begin
      if (instr_req && instr_gnt) begin
        resp_idx = int'((instr_addr - BOOT_ADDR) >> 2);
        assert (resp_idx >= 0 && resp_idx < NUM_INSTR)
          else abort_run("instruction fetched outside the program");
        pending   = 1'b1;
        resp_wait = $urandom_range(2, 0);  // rvalid 1 to 3 cycles later
        gnt_wait  = $urandom_range(2, 0);  // Next grant 0 to 2 cycles late
        if (resp_idx >= NUM_INSTR - 4) begin
          // Tail words back to back so EX bypass and write-through both fire
          resp_wait = 0;
          gnt_wait  = 0;
        end
      end else if (instr_req && gnt_wait > 0) begin
        gnt_wait--;
      end
      instr_gnt    <= (gnt_wait == 0);
      instr_rvalid <= 1'b0;
      if (pending) begin
        if (resp_wait == 0) begin
          instr_rvalid <= 1'b1;
          instr_rdata  <= prog[resp_idx];
          pending = 1'b0;
        end else begin
          resp_wait--;
        end
      end
    end
  end

  ////////////////////////////////////////
  // Bus and write port monitor
  ////////////////////////////////////////

  always @(posedge clk) begin
    logic                we;
    core_pkg::reg_addr_t rd;
    core_pkg::xlen_t     val;
    wr_t                 head;
    if (rst) begin
      next_addr = boot_addr;
      we_pipe   = '0;
      for (int i = 0; i < 32; i++) begin
        ref_regs[i] = '0;
      end
    end else begin
      if (instr_req) begin
        assert (instr_addr === next_addr) else abort_run($sformatf(
          "[FAIL] instr_addr_o got %08h expected %08h", instr_addr, next_addr));
      end
      if (instr_req && instr_gnt) next_addr = next_addr + 32'd4;  // Sequential fetch
      // Write three edges after the rvalid edge
      assert (rf_we_wb === we_pipe[2]) else abort_run($sformatf(
        "[FAIL] rf_we_wb_o got %0h expected %0h", rf_we_wb, we_pipe[2]));
      if (rf_we_wb) begin
        assert (exp_writes.size() > 0) else abort_run("register write with none expected");
        head = exp_writes.pop_front();
        assert (rf_waddr_wb === head.rd) else abort_run($sformatf(
          "[FAIL] rf_waddr_wb_o got %02h expected %02h", rf_waddr_wb, head.rd));
        assert (rf_wdata_wb === head.value) else abort_run($sformatf(
          "[FAIL] rf_wdata_wb_o got %08h expected %08h", rf_wdata_wb, head.value));
        observed++;
      end
      we = 1'b0;
      if (instr_rvalid) begin
        predict(instr_rdata, we, rd, val);
        retired++;
        if (we) begin
          ref_regs[rd] = val;
          exp_writes.push_back('{rd: rd, value: val});
          predicted++;
        end
      end
      we_pipe = {we_pipe[1:0], we};
    end
  end

  // New request only with fetch enabled, held ones excepted
  a_new_req_enabled: assert property (@(posedge clk) disable iff (rst)
    (instr_req && !$past(instr_req && !instr_gnt)) |-> fetch_enable)
    else abort_run("new instruction request started while fetch was disabled");

  a_req_held: assert property (@(posedge clk) disable iff (rst)
    (instr_req && !instr_gnt) |=> (instr_req && $stable(instr_addr)))
    else abort_run("instruction request or address changed before grant");

  a_wb_latency: assert property (@(posedge clk) disable iff (rst)
    rf_we_wb |-> $past(instr_rvalid, 3))
    else abort_run("register write without an rvalid three cycles before");

  // Busy from request until the word has left WB
  a_busy_in_flight: assert property (@(posedge clk) disable iff (rst)
    (instr_req || instr_rvalid || $past(instr_rvalid) || $past(instr_rvalid, 2) ||
     $past(instr_rvalid, 3)) |-> core_busy)
    else abort_run("core busy low with an instruction still in flight");

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Enable fetch until n more grants, drop on the last grant edge
  task automatic run_fetch(input int n_grants);
    int seen;
    int cycles;
    seen   = 0;
    cycles = 0;
    fetch_enable <= 1'b1;
    while (seen < n_grants) begin
      @(posedge clk);
      cycles++;
      assert (cycles < TIMEOUT) else abort_run("timeout waiting for instruction grants");
      if (instr_req && instr_gnt) seen++;
    end
    fetch_enable <= 1'b0;
  endtask

  task automatic await_drain();
    int cycles;
    cycles = 0;
    while (core_busy) begin
      @(posedge clk);
      cycles++;
      assert (cycles < TIMEOUT) else abort_run("timeout waiting for the core to go idle");
    end
  endtask

  initial begin
    void'($urandom(2832));
    retired   = 0;
    predicted = 0;
    observed  = 0;
    prog[0]  = enc_u('h80001, 1);          // lui x1
    prog[1]  = enc_i(-5, 0, 0, 2);         // addi x2, x0, -5
    prog[2]  = enc_i('h123, 1, 0, 1);      // Reads x1 from the lui
    prog[3]  = enc_r(0, 2, 1, 0, 3);       // add, x2 via write-through
    prog[4]  = enc_r('h20, 1, 3, 0, 4);    // sub
    prog[5]  = enc_r(0, 2, 4, 1, 5);       // sll by 27
    prog[6]  = enc_r(0, 1, 2, 2, 6);       // slt
    prog[7]  = enc_r(0, 1, 2, 3, 7);       // sltu
    prog[8]  = enc_r(0, 6, 7, 4, 8);       // xor
    prog[9]  = enc_r(0, 2, 1, 5, 9);       // srl
    prog[10] = enc_r('h20, 2, 1, 5, 10);   // sra
    prog[11] = enc_r(0, 9, 10, 6, 11);     // or
    prog[12] = enc_r(0, 1, 11, 7, 12);     // and, first after pause
    prog[13] = enc_i(5, 1, 0, 0);          // rd x0
    prog[14] = 32'hFFFF_FFFF;              // Illegal opcode
    prog[15] = enc_i(-4, 2, 2, 13);        // slti
    prog[16] = enc_i(1, 2, 3, 14);         // sltiu
    prog[17] = enc_i('h7ff, 14, 4, 15);    // xori
    prog[18] = enc_i(-256, 15, 6, 16);     // ori
    prog[19] = enc_i('h0f0, 16, 7, 17);    // andi
    prog[20] = enc_i(4, 17, 1, 18);        // slli
    prog[21] = enc_i(8, 1, 5, 19);         // srli
    prog[22] = enc_i('h408, 1, 5, 20);     // srai
    prog[23] = enc_r(0, 2, 1, 0, 0);       // add to x0
    prog[24] = enc_r('h20, 20, 20, 0, 21); // sub to zero
    prog[25] = enc_u('hfffff, 22);         // lui
    prog[26] = enc_r(0, 21, 22, 0, 23);    // add
    prog[27] = enc_r(0, 23, 23, 0, 24);    // Dependent pair
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    assert (!instr_req) else abort_run($sformatf("[FAIL] instr_req_o got %0h expected 0",
                                                 instr_req));
    assert (!rf_we_wb) else abort_run($sformatf("[FAIL] rf_we_wb_o got %0h expected 0",
                                                rf_we_wb));
    assert (!core_busy) else abort_run($sformatf("[FAIL] core_busy_o got %0h expected 0",
                                                 core_busy));
    run_fetch(PAUSE_AT);
    await_drain();
    // Stays quiet while fetch is off
    repeat (5) begin
      @(posedge clk);
      assert (!instr_req) else abort_run("instruction request while fetch disabled");
      assert (!core_busy) else abort_run("core busy with nothing in flight");
    end
    assert (retired == PAUSE_AT && exp_writes.size() == 0)
      else abort_run("pipeline did not drain before the pause");
    run_fetch(NUM_INSTR - PAUSE_AT);
    await_drain();
    repeat (2) @(posedge clk);
    if (retired == NUM_INSTR && observed == predicted && exp_writes.size() == 0) begin
      $display("TEST OK");
      $finish;
    end else begin
      abort_run($sformatf("incomplete run, %0d of %0d retired, %0d of %0d writes",
                          retired, NUM_INSTR, observed, predicted));
    end
  end

endmodule

`default_nettype wire
